//--- rtl/cfu_op_pkg.sv
/*
  custom-function unit operation encodings, word widths
  and the command sequencer state type
*/
`default_nettype none

package cfu_op_pkg;

  ////////////////////////////////////////////////
  // word widths
  ////////////////////////////////////////////////
  localparam int word_w        = 32;
  localparam int funct3_w      = 3;
  localparam int function_id_w = 10;

  // response to an instruction-memory write
  localparam logic [word_w-1:0] ack_word = '1;

  ////////////////////////////////////////////////
  // funct3 encodings, low bits of the function id
  ////////////////////////////////////////////////
  typedef enum logic [funct3_w-1:0] {
    byte_sum    = 3'd0,
    byte_swap   = 3'd1,
    bit_reverse = 3'd2,
    write_instr = 3'd3,
    read_instr  = 3'd4
  } cfu_funct3_e;

  // operations of the arithmetic unit
  typedef enum logic [1:0] {
    sum     = 2'd0,
    swap    = 2'd1,
    reverse = 2'd2
  } alu_op_e;

  // command sequencer states
  typedef enum logic [1:0] {
    idle     = 2'd0,
    exec     = 2'd1,
    mem_wait = 2'd2,
    respond  = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

//--- rtl/cfu_mem_pkg.sv
/*
  instruction store geometry
*/
`default_nettype none

package cfu_mem_pkg;

  ////////////////////////////////////////////////
  // instruction store
  ////////////////////////////////////////////////

  // 9-bit word address taken from operand 0
  localparam int instr_addr_w = 9;

  // one word per address
  localparam int instr_depth  = 512;

  // stored word width, same as the cpu word
  localparam int instr_data_w = 32;

endpackage

`default_nettype wire

//--- rtl/cfu_alu.sv
/*
  arithmetic unit of the cfu, computes byte sum, byte swap
  or bit reverse and registers the result one cycle after go
*/
`timescale 1ns/1ns
`default_nettype none

module cfu_alu import cfu_op_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic [word_w-1:0] alu_a,
  input  logic [word_w-1:0] alu_b,
  input  alu_op_e           alu_op,
  input  logic              alu_go,
  output logic [word_w-1:0] alu_result
);

  logic [word_w-1:0] sum_word;
  logic [word_w-1:0] swap_word;
  logic [word_w-1:0] rev_word;
  logic [word_w-1:0] next_result;

  ////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////

  // low bytes only, zero-extended so the carry lands in bit 8
  assign sum_word = {{(word_w-8){1'b0}}, alu_a[7:0]} + {{(word_w-8){1'b0}}, alu_b[7:0]};

  // byte order reversed
  assign swap_word = {alu_a[7:0], alu_a[15:8], alu_a[23:16], alu_a[31:24]};

  // bit order reversed
  always_comb begin
    for (int i = 0; i < word_w; i++) begin
      rev_word[i] = alu_a[word_w-1-i];
    end
  end

  // operation select
  always_comb begin
    case (alu_op)
      sum:     next_result = sum_word;
      swap:    next_result = swap_word;
      reverse: next_result = rev_word;
      default: next_result = '0;
    endcase
  end

  ////////////////////////////////////////////////
  // result register, holds between operations
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      alu_result <= '0;
    end else if (alu_go) begin
      alu_result <= next_result;
    end
  end

endmodule

`default_nettype wire

//--- rtl/instr_store.sv
/*
  single-port instruction memory with synchronous write
  and a registered read
*/
`timescale 1ns/1ns
`default_nettype none

module instr_store import cfu_mem_pkg::*; (
  input  logic                    clk,
  input  logic [instr_addr_w-1:0] mem_addr,
  input  logic [instr_data_w-1:0] mem_wdata,
  input  logic                    mem_we,
  output logic [instr_data_w-1:0] mem_rdata
);

  ////////////////////////////////////////////////
  // storage array
  ////////////////////////////////////////////////

  // contents undefined until written
  logic [instr_data_w-1:0] mem [instr_depth];

  // write takes effect on the edge where we is high
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  ////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////

  // read every cycle, data follows the address by one edge
  // a read in the write cycle returns the old word
  always_ff @(posedge clk) begin
    mem_rdata <= mem[mem_addr];
  end

endmodule

`default_nettype wire

//--- rtl/cfu_sequencer.sv
/*
  cfu command sequencer, captures a command, drives the alu or the
  instruction store and returns the result over the rsp handshake
*/
`timescale 1ns/1ns
`default_nettype none

module cfu_sequencer
  import cfu_op_pkg::*;
  import cfu_mem_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  // command channel
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  logic [function_id_w-1:0] cmd_payload_function_id,
  input  logic [word_w-1:0]        cmd_payload_inputs_0,
  input  logic [word_w-1:0]        cmd_payload_inputs_1,
  // response channel
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output logic [word_w-1:0]        rsp_payload_outputs_0,
  // arithmetic unit
  output logic [word_w-1:0]        alu_a,
  output logic [word_w-1:0]        alu_b,
  output alu_op_e                  alu_op,
  output logic                     alu_go,
  input  logic [word_w-1:0]        alu_result,
  // instruction store
  output logic [instr_addr_w-1:0]  mem_addr,
  output logic [word_w-1:0]        mem_wdata,
  output logic                     mem_we,
  input  logic [word_w-1:0]        mem_rdata
);

  seq_state_e        state;
  cfu_funct3_e       funct3_q;
  logic [word_w-1:0] op0_q;
  logic [word_w-1:0] op1_q;
  logic [word_w-1:0] rsp_word;
  logic              is_alu_op;

  ////////////////////////////////////////////////
  // command capture
  ////////////////////////////////////////////////

  // funct7 is ignored, only funct3 is kept
  always_ff @(posedge clk) begin
    if (state == idle && cmd_valid) begin
      funct3_q <= cfu_funct3_e'(cmd_payload_function_id[funct3_w-1:0]);
      op0_q    <= cmd_payload_inputs_0;
      op1_q    <= cmd_payload_inputs_1;
    end
  end

  // accept only while idle
  assign cmd_ready = (state == idle);

  ////////////////////////////////////////////////
  // decode and unit controls
  ////////////////////////////////////////////////
  always_comb begin
    is_alu_op = 1'b1;
    alu_op    = sum;
    case (funct3_q)
      byte_sum:    alu_op = sum;
      byte_swap:   alu_op = swap;
      bit_reverse: alu_op = reverse;
      default:     is_alu_op = 1'b0;
    endcase
  end

  assign alu_a  = op0_q;
  assign alu_b  = op1_q;
  assign alu_go = (state == exec) && is_alu_op;

  // address held from capture so the registered read stays valid
  assign mem_addr  = op0_q[instr_addr_w-1:0];
  assign mem_wdata = op1_q;
  assign mem_we    = (state == exec) && (funct3_q == write_instr);

  // response word by decoded operation, unknown funct3 gives zero
  always_comb begin
    case (funct3_q)
      byte_sum, byte_swap, bit_reverse: rsp_word = alu_result;
      write_instr:                      rsp_word = ack_word;
      read_instr:                       rsp_word = mem_rdata;
      default:                          rsp_word = '0;
    endcase
  end

  ////////////////////////////////////////////////
  // handshake fsm
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= idle;
      rsp_valid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (cmd_valid) begin
            state <= exec;
          end
        end
        // reads need one more cycle for the registered memory
        exec: begin
          state <= (funct3_q == read_instr) ? mem_wait : respond;
        end
        mem_wait: begin
          state <= respond;
        end
        respond: begin
          if (!rsp_valid) begin
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            // response taken, back to accepting commands
            rsp_valid <= 1'b0;
            state     <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // payload loads once on entry to respond, then holds
  always_ff @(posedge clk) begin
    if (state == respond && !rsp_valid) begin
      rsp_payload_outputs_0 <= rsp_word;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cfu_top.sv
/*
  custom-function unit top, joins the command sequencer with
  the arithmetic unit and the instruction store
*/
`timescale 1ns/1ns
`default_nettype none

module cfu_top
  import cfu_op_pkg::*;
  import cfu_mem_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  logic [function_id_w-1:0] cmd_payload_function_id,
  input  logic [word_w-1:0]        cmd_payload_inputs_0,
  input  logic [word_w-1:0]        cmd_payload_inputs_1,
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output logic [word_w-1:0]        rsp_payload_outputs_0
);

  // sequencer to alu
  logic [word_w-1:0]       alu_a;
  logic [word_w-1:0]       alu_b;
  alu_op_e                 alu_op;
  logic                    alu_go;
  logic [word_w-1:0]       alu_result;

  // sequencer to instruction store
  logic [instr_addr_w-1:0] mem_addr;
  logic [word_w-1:0]       mem_wdata;
  logic                    mem_we;
  logic [word_w-1:0]       mem_rdata;

  ////////////////////////////////////////////////
  // command sequencer
  ////////////////////////////////////////////////
  cfu_sequencer cfu_sequencer_i (
    .clk, .resetn,
    .cmd_valid, .cmd_ready, .cmd_payload_function_id,
    .cmd_payload_inputs_0, .cmd_payload_inputs_1,
    .rsp_valid, .rsp_ready, .rsp_payload_outputs_0,
    .alu_a, .alu_b, .alu_op, .alu_go, .alu_result,
    .mem_addr, .mem_wdata, .mem_we, .mem_rdata
  );

  ////////////////////////////////////////////////
  // alu and instruction store, side by side
  ////////////////////////////////////////////////
  cfu_alu cfu_alu_i (
    .clk, .resetn,
    .alu_a, .alu_b, .alu_op, .alu_go, .alu_result
  );

  instr_store instr_store_i (
    .clk,
    .mem_addr, .mem_wdata, .mem_we, .mem_rdata
  );

endmodule

`default_nettype wire

//--- sim/cfu_tb.sv
/*
  cfu testbench that replays command vectors from a file with
  random rsp_ready stalls and checks results and response timing
*/
`timescale 1ns/1ns
`default_nettype none

module cfu_tb
  import cfu_op_pkg::*;
  import cfu_mem_pkg::*;
();

  logic                     clk;
  logic                     resetn;
  logic                     cmd_valid;
  logic                     cmd_ready;
  logic [function_id_w-1:0] cmd_payload_function_id;
  logic [word_w-1:0]        cmd_payload_inputs_0;
  logic [word_w-1:0]        cmd_payload_inputs_1;
  logic                     rsp_valid;
  logic                     rsp_ready;
  logic [word_w-1:0]        rsp_payload_outputs_0;

  // one entry per vector line
  logic [function_id_w-1:0] vec_fid [$];
  logic [word_w-1:0]        vec_op0 [$];
  logic [word_w-1:0]        vec_op1 [$];
  logic [word_w-1:0]        vec_exp [$];

  int errors;
  int failed_tests;
  bit loaded;

  cfu_top cfu_top_i (
    .clk, .resetn,
    .cmd_valid, .cmd_ready, .cmd_payload_function_id,
    .cmd_payload_inputs_0, .cmd_payload_inputs_1,
    .rsp_valid, .rsp_ready, .rsp_payload_outputs_0
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////
  task automatic check_result(input int n, input logic [word_w-1:0] exp_word,
                              input logic [word_w-1:0] act_word);
    if (act_word !== exp_word) begin
      $display("MISMATCH at %0t ns: test %0d result expected %h got %h",
               $time, n, exp_word, act_word);
      errors++;
    end
  endtask

  task automatic check_latency(input int n, input int exp_cycles, input int act_cycles);
    if (act_cycles != exp_cycles) begin
      $display("MISMATCH at %0t ns: test %0d latency expected %0d got %0d",
               $time, n, exp_cycles, act_cycles);
      errors++;
    end
  endtask

  // handshake rule broken
  task automatic protocol_error(input int n, input string what);
    $display("ERROR at %0t ns: test %0d: %s", $time, n, what);
    errors++;
  endtask

  ////////////////////////////////////////////////
  // vector file
  ////////////////////////////////////////////////
  task automatic load_vectors();
    int                       fd;
    int                       code;
    logic [8*128-1:0]         line;
    logic [function_id_w-1:0] fid;
    logic [word_w-1:0]        op0;
    logic [word_w-1:0]        op1;
    logic [word_w-1:0]        exp_word;
    fd = $fopen("sim/cfu_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the vector file sim/cfu_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // comment lines do not parse as four hex fields
        if (code > 0 && $sscanf(line, "%h %h %h %h", fid, op0, op1, exp_word) == 4) begin
          vec_fid.push_back(fid);
          vec_op0.push_back(op0);
          vec_op1.push_back(op1);
          vec_exp.push_back(exp_word);
        end
      end
      $fclose(fd);
    end
    if (vec_fid.size() == 0) begin
      $display("ERROR: no vectors were loaded");
      errors++;
    end
  endtask

  ////////////////////////////////////////////////
  // one command through the handshake
  ////////////////////////////////////////////////
  task automatic run_test(input int n);
    cfu_funct3_e       f3;
    logic [word_w-1:0] held;
    int                exp_lat;
    int                cycles;
    int                stall;
    int                errs_before;
    errs_before = errors;
    f3          = cfu_funct3_e'(vec_fid[n][funct3_w-1:0]);
    // reads spend one extra cycle in the registered memory
    exp_lat     = (f3 == read_instr) ? 3 : 2;
    stall       = $urandom % 4;
    cmd_valid               = 1'b1;
    cmd_payload_function_id = vec_fid[n];
    cmd_payload_inputs_0    = vec_op0[n];
    cmd_payload_inputs_1    = vec_op1[n];
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
    end
    // accept edge
    @(posedge clk);
    #1;
    cmd_valid               = 1'b0;
    cmd_payload_function_id = '0;
    cmd_payload_inputs_0    = '0;
    cmd_payload_inputs_1    = '0;
    cycles = 0;
    while (!rsp_valid) begin
      if (cmd_ready) protocol_error(n, "cmd_ready high before the response completed");
      @(posedge clk);
      #1;
      cycles++;
    end
    held = rsp_payload_outputs_0;
    check_latency(n, exp_lat, cycles);
    check_result(n, vec_exp[n], held);
    // response must hold under back-pressure
    repeat (stall) begin
      @(posedge clk);
      #1;
      if (!rsp_valid) protocol_error(n, "rsp_valid dropped while rsp_ready was low");
      if (rsp_payload_outputs_0 !== held) protocol_error(n, "payload changed during a stall");
      if (cmd_ready) protocol_error(n, "cmd_ready high during a stall");
    end
    rsp_ready = 1'b1;
    @(posedge clk);
    #1;
    rsp_ready = 1'b0;
    if (rsp_valid) protocol_error(n, "rsp_valid still high after the response completed");
    if (!cmd_ready) protocol_error(n, "cmd_ready did not return after the response");
    if (errors != errs_before) failed_tests++;
    $display("test %0d funct3 %0d addr %h result %h latency %0d stall %0d %s",
             n, vec_fid[n][funct3_w-1:0], vec_op0[n][instr_addr_w-1:0], held,
             cycles, stall, (errors == errs_before) ? "ok" : "error");
  endtask

  ////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////
  initial begin
    void'($urandom(87));
    resetn                  = 1'b0;
    cmd_valid               = 1'b0;
    cmd_payload_function_id = '0;
    cmd_payload_inputs_0    = '0;
    cmd_payload_inputs_1    = '0;
    rsp_ready               = 1'b0;
    errors                  = 0;
    failed_tests            = 0;
    loaded                  = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    resetn = 1'b1;
    // idle handshake state out of reset
    if (!cmd_ready) protocol_error(0, "cmd_ready low right after reset");
    if (rsp_valid) protocol_error(0, "rsp_valid high right after reset");
    for (int n = 0; n < vec_fid.size(); n++) begin
      run_test(n);
    end
    $display("tests %0d, failed tests %0d, errors %0d", vec_fid.size(), failed_tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog with 20 cycles per vector plus slack for reset
  initial begin
    wait (loaded);
    repeat (vec_fid.size() * 20 + 100) @(posedge clk);
    $display("ERROR: the run did not finish in time, the DUT appears to hang");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/cfu_vectors.txt
// function_id operand_0 operand_1 expected_result, all hex
// funct3 is function_id[2:0], funct7 above it is ignored
000 000000ff 00000001 00000100
000 12345678 9abcdef0 00000168
380 aaaaaa80 55555580 00000100
001 12345678 00000000 78563412
001 deadbeef ffffffff efbeadde
002 00000001 00000000 80000000
002 12345678 00000000 1e6a2c48
002 f0f0000f 00000000 f0000f0f
003 00000010 cafef00d ffffffff
003 00000020 0badc0de ffffffff
003 000001ff 13579bdf ffffffff
003 00000105 2468ace0 ffffffff
003 fffffe07 a5a55a5a ffffffff
004 00000010 00000000 cafef00d
004 00000020 ffffffff 0badc0de
004 000001ff 00000000 13579bdf
004 00000105 00000000 2468ace0
004 00000207 00000000 a5a55a5a
3fc 00000010 00000000 cafef00d
003 00000010 11111111 ffffffff
004 00000010 00000000 11111111
005 ffffffff ffffffff 00000000
006 12345678 9abcdef0 00000000
007 deadbeef 00000000 00000000
3ff ffffffff ffffffff 00000000
2bd 00000010 cafef00d 00000000
00e 00000105 00000000 00000000
001 000000ff 00000000 ff000000
040 00000000 00000000 00000000

//--- sources.f
rtl/cfu_op_pkg.sv
rtl/cfu_mem_pkg.sv
rtl/cfu_alu.sv
rtl/instr_store.sv
rtl/cfu_sequencer.sv
rtl/cfu_top.sv
sim/cfu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= cfu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
